// File: all.f
mem_pkg.sv
mem_lane_select.sv
ms_ctrl.sv
store_format.sv
load_extend.sv
data_ram.sv
mem_stage.sv
tb_clk_gen.sv
tb_mem_stage.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_stage -f all.f \
    -o tb_sim > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_sim 2>&1 | tee sim.log
grep -q "All tests passed" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// File: tb_mem_stage.sv
`timescale 1ns/1ns

module tb_mem_stage;

    typedef logic [mem_pkg::XLEN-1:0] word_t;

    localparam int RAM_DEPTH      = 256;  // DUT default
    localparam int RESET_CYCLES   = 10;
    localparam int N_OPS          = 101;  // Operations issued over all tests
    localparam int TIMEOUT_CYCLES = 40 * N_OPS + RESET_CYCLES;

    logic                clk;
    logic                rst_n;
    mem_pkg::mem_op_e    l0_op;
    mem_pkg::mem_width_e l0_width;
    logic                l0_unsigned;
    word_t               l0_addr;
    word_t               l0_wdata;
    word_t               l0_pc;
    mem_pkg::mem_op_e    l1_op;
    mem_pkg::mem_width_e l1_width;
    logic                l1_unsigned;
    word_t               l1_addr;
    word_t               l1_wdata;
    word_t               l1_pc;
    logic                flush;
    logic                ms_done;
    word_t               ms_result;
    logic                excp_ale;
    word_t               excp_pc;

    word_t  ref_mem [RAM_DEPTH];  // Reference memory model
    word_t  res_data;
    word_t  res_pc;
    logic   res_ale;
    int     res_cycles;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;
    int     err_base = 0;
    int     ops_issued = 0;
    int     cycle_count = 0;
    integer seed = 65;

    tb_clk_gen #(.HALF_PERIOD(2), .RESET_CYCLES(RESET_CYCLES)) clk_gen_i (
        .clk(clk), .rst_n(rst_n)
    );

    mem_stage dut_i (
        .clk(clk), .rst_n(rst_n),
        .l0_op(l0_op), .l0_width(l0_width), .l0_unsigned(l0_unsigned),
        .l0_addr(l0_addr), .l0_wdata(l0_wdata), .l0_pc(l0_pc),
        .l1_op(l1_op), .l1_width(l1_width), .l1_unsigned(l1_unsigned),
        .l1_addr(l1_addr), .l1_wdata(l1_wdata), .l1_pc(l1_pc),
        .flush(flush),
        .ms_done(ms_done), .ms_result(ms_result),
        .excp_ale(excp_ale), .excp_pc(excp_pc)
    );

    task automatic check_data(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s: got %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_excp(input string what, input logic got_ale, input word_t got_pc,
                              input logic exp_ale, input word_t exp_pc);
        checks++;
        if (got_ale !== exp_ale || got_pc !== exp_pc) begin
            errors++;
            $display("[ERROR] %0t ns: %s: excp_ale %b pc %08h, expected %b pc %08h",
                     $time, what, got_ale, got_pc, exp_ale, exp_pc);
        end
    endtask

    task automatic check_latency(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s: done after %0d cycles, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    function automatic int word_index(input word_t addr);
        return int'((addr >> 2) % RAM_DEPTH);
    endfunction

    // Byte lane rule: low byte or half goes to the lane named by the address
    function automatic void model_store(input word_t addr, input mem_pkg::mem_width_e width,
                                        input word_t data);
        int i;
        i = word_index(addr);
        case (width)
            mem_pkg::W_BYTE: ref_mem[i][int'(addr[1:0]) * 8 +: 8] = data[7:0];
            mem_pkg::W_HALF: ref_mem[i][int'(addr[1]) * 16 +: 16] = data[15:0];
            default:         ref_mem[i] = data;
        endcase
    endfunction

    function automatic word_t model_load(input word_t addr, input mem_pkg::mem_width_e width,
                                         input logic uns);
        word_t       w;
        logic [7:0]  b;
        logic [15:0] h;
        w = ref_mem[word_index(addr)];
        b = w[int'(addr[1:0]) * 8 +: 8];
        h = w[int'(addr[1]) * 16 +: 16];
        case (width)
            mem_pkg::W_BYTE: return uns ? {24'h0, b} : {{24{b[7]}}, b};
            mem_pkg::W_HALF: return uns ? {16'h0, h} : {{16{h[15]}}, h};
            default:         return w;
        endcase
    endfunction

    task automatic clear_lanes();
        l0_op = mem_pkg::MEM_NONE;
        l0_width = mem_pkg::W_BYTE;
        l0_unsigned = 1'b0;
        l0_addr = '0;
        l0_wdata = '0;
        l0_pc = '0;
        l1_op = mem_pkg::MEM_NONE;
        l1_width = mem_pkg::W_BYTE;
        l1_unsigned = 1'b0;
        l1_addr = '0;
        l1_wdata = '0;
        l1_pc = '0;
    endtask

    task automatic set_lane(input int lane, input mem_pkg::mem_op_e op,
                            input mem_pkg::mem_width_e width, input logic uns,
                            input word_t addr, input word_t wdata, input word_t pc);
        if (lane == 0) begin
            l0_op = op;
            l0_width = width;
            l0_unsigned = uns;
            l0_addr = addr;
            l0_wdata = wdata;
            l0_pc = pc;
        end else begin
            l1_op = op;
            l1_width = width;
            l1_unsigned = uns;
            l1_addr = addr;
            l1_wdata = wdata;
            l1_pc = pc;
        end
    endtask

    // Issue strobe lasts one cycle, then count falling edges until ms_done
    task automatic wait_done();
        ops_issued++;
        @(negedge clk);
        clear_lanes();
        res_cycles = 1;
        while (!ms_done) begin
            @(negedge clk);
            res_cycles++;
        end
        res_data = ms_result;
        res_ale = excp_ale;
        res_pc = excp_pc;
        @(negedge clk);  // Done strobe over, FSM back in S_IDLE
    endtask

    task automatic store_and_check(input int lane, input mem_pkg::mem_width_e width,
                                   input word_t addr, input word_t data, input word_t pc);
        set_lane(lane, mem_pkg::MEM_STORE, width, 1'b0, addr, data, pc);
        wait_done();
        check_data($sformatf("store %08h result", addr), res_data, '0);
        check_excp($sformatf("store %08h", addr), res_ale, res_pc, 1'b0, '0);
        check_latency($sformatf("store %08h", addr), res_cycles, 2);
        model_store(addr, width, data);
    endtask

    task automatic load_and_check(input int lane, input mem_pkg::mem_width_e width,
                                  input logic uns, input word_t addr, input word_t pc);
        set_lane(lane, mem_pkg::MEM_LOAD, width, uns, addr, '0, pc);
        wait_done();
        check_data($sformatf("load %08h width %0d unsigned %b", addr, width, uns),
                   res_data, model_load(addr, width, uns));
        check_excp($sformatf("load %08h", addr), res_ale, res_pc, 1'b0, '0);
        check_latency($sformatf("load %08h", addr), res_cycles, 2);
    endtask

    task automatic misaligned_and_check(input int lane, input mem_pkg::mem_op_e op,
                                        input mem_pkg::mem_width_e width,
                                        input word_t addr, input word_t pc);
        set_lane(lane, op, width, 1'b0, addr, 32'hFFFF_FFFF, pc);
        wait_done();
        check_data($sformatf("misaligned %08h result", addr), res_data, '0);
        check_excp($sformatf("misaligned %08h", addr), res_ale, res_pc, 1'b1, pc);
        check_latency($sformatf("misaligned %08h", addr), res_cycles, 1);
    endtask

    task automatic word_roundtrip();
        store_and_check(0, mem_pkg::W_WORD, 32'h40, 32'hDEAD_BEEF, 32'h100);
        load_and_check(0, mem_pkg::W_WORD, 1'b0, 32'h40, 32'h104);
    endtask

    // Upper bits of wdata are junk on purpose, only the low byte or half counts
    task automatic subword_access();
        word_t addr;
        int    k;
        store_and_check(0, mem_pkg::W_WORD, 32'h80, 32'hA5A5_5A5A, 32'h200);
        for (k = 0; k < 4; k++) begin
            addr = 32'h80 + k;
            store_and_check(k % 2, mem_pkg::W_BYTE, addr, 32'h7F80_C33C >> (8 * k), 32'h204);
            load_and_check(0, mem_pkg::W_BYTE, 1'b0, addr, 32'h208);
            load_and_check(1, mem_pkg::W_BYTE, 1'b1, addr, 32'h20C);
            load_and_check(0, mem_pkg::W_WORD, 1'b0, 32'h80, 32'h210);
        end
        store_and_check(0, mem_pkg::W_WORD, 32'h90, 32'h1234_5678, 32'h214);
        for (k = 0; k < 4; k += 2) begin
            addr = 32'h90 + k;
            store_and_check(1, mem_pkg::W_HALF, addr, 32'h8001_7FFE >> (8 * k), 32'h218);
            load_and_check(0, mem_pkg::W_HALF, 1'b0, addr, 32'h21C);
            load_and_check(1, mem_pkg::W_HALF, 1'b1, addr, 32'h220);
            load_and_check(0, mem_pkg::W_WORD, 1'b0, 32'h90, 32'h224);
        end
    endtask

    task automatic dual_issue();
        store_and_check(0, mem_pkg::W_WORD, 32'hA0, 32'h0101_0101, 32'h300);
        store_and_check(1, mem_pkg::W_WORD, 32'hA4, 32'h0202_0202, 32'h304);
        set_lane(0, mem_pkg::MEM_STORE, mem_pkg::W_WORD, 1'b0, 32'hA0, 32'hCAFE_0000, 32'h308);
        set_lane(1, mem_pkg::MEM_STORE, mem_pkg::W_WORD, 1'b0, 32'hA4, 32'hBEEF_1111, 32'h30C);
        wait_done();
        check_data("dual issue result", res_data, '0);
        check_excp("dual issue", res_ale, res_pc, 1'b0, '0);
        check_latency("dual issue", res_cycles, 2);
        model_store(32'hA0, mem_pkg::W_WORD, 32'hCAFE_0000);  // Lane 0 only
        load_and_check(0, mem_pkg::W_WORD, 1'b0, 32'hA0, 32'h310);
        load_and_check(1, mem_pkg::W_WORD, 1'b0, 32'hA4, 32'h314);
    endtask

    task automatic misaligned_access();
        store_and_check(0, mem_pkg::W_WORD, 32'hC0, 32'h5566_7788, 32'h400);
        misaligned_and_check(0, mem_pkg::MEM_STORE, mem_pkg::W_HALF, 32'hC1, 32'h1000);
        misaligned_and_check(1, mem_pkg::MEM_LOAD, mem_pkg::W_WORD, 32'hC2, 32'h2004);
        misaligned_and_check(0, mem_pkg::MEM_STORE, mem_pkg::W_WORD, 32'hC3, 32'h3008);
        load_and_check(0, mem_pkg::W_WORD, 1'b0, 32'hC0, 32'h404);
    endtask

    task automatic flush_cancel();
        logic quiet;
        store_and_check(0, mem_pkg::W_WORD, 32'hD0, 32'h0BAD_F00D, 32'h500);
        flush = 1'b1;
        set_lane(0, mem_pkg::MEM_STORE, mem_pkg::W_WORD, 1'b0, 32'hD0, 32'h1234_5678, 32'h504);
        ops_issued++;
        quiet = 1'b1;
        repeat (4) begin
            @(negedge clk);
            clear_lanes();
            flush = 1'b0;
            if (ms_done)
                quiet = 1'b0;
        end
        checks++;
        if (!quiet) begin
            errors++;
            $display("A flushed store still completed with ms_done at %0t ns", $time);
        end
        load_and_check(1, mem_pkg::W_WORD, 1'b0, 32'hD0, 32'h508);
    endtask

    // Upper address bits are random too, so the word index wraps
    task automatic random_words();
        word_t addr;
        word_t data;
        word_t written [$];
        int    pick;
        int    i;
        for (i = 0; i < 30; i++) begin
            addr = $random(seed) & 32'hFFFF_FFFC;
            data = $random(seed);
            store_and_check(i % 2, mem_pkg::W_WORD, addr, data, 32'h600 + 8 * i);
            written.push_back(addr);
            pick = $unsigned($random(seed)) % written.size();
            load_and_check((i + 1) % 2, mem_pkg::W_WORD, 1'b0, written[pick], 32'h604 + 8 * i);
        end
    endtask

    task automatic begin_test();
        err_base = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%-24s %s", name, (errors == err_base) ? "ok" : "FAILED");
    endtask

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Simulation timed out after %0d cycles", cycle_count);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        clear_lanes();
        flush = 1'b0;
        @(posedge rst_n);
        @(negedge clk);
        check_excp("idle after reset", excp_ale, excp_pc, 1'b0, '0);
        begin_test();
        word_roundtrip();
        end_test("word store and load");
        begin_test();
        subword_access();
        end_test("byte and half access");
        begin_test();
        dual_issue();
        end_test("dual lane issue");
        begin_test();
        misaligned_access();
        end_test("misaligned access");
        begin_test();
        flush_cancel();
        end_test("flush cancel");
        begin_test();
        random_words();
        end_test("random words");
        $display("%0d tests, %0d operations, %0d checks, %0d errors",
                 tests, ops_issued, checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release on a falling edge so the first active edge sees a clean level
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: mem_stage.sv
`timescale 1ns/1ns

module mem_stage #(
    parameter int unsigned RAM_DEPTH = 256
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  mem_pkg::mem_op_e           l0_op,
    input  mem_pkg::mem_width_e        l0_width,
    input  logic                       l0_unsigned,
    input  logic [mem_pkg::XLEN-1:0]   l0_addr,
    input  logic [mem_pkg::XLEN-1:0]   l0_wdata,
    input  logic [mem_pkg::XLEN-1:0]   l0_pc,
    input  mem_pkg::mem_op_e           l1_op,
    input  mem_pkg::mem_width_e        l1_width,
    input  logic                       l1_unsigned,
    input  logic [mem_pkg::XLEN-1:0]   l1_addr,
    input  logic [mem_pkg::XLEN-1:0]   l1_wdata,
    input  logic [mem_pkg::XLEN-1:0]   l1_pc,
    input  logic                       flush,
    output logic                       ms_done,
    output logic [mem_pkg::XLEN-1:0]   ms_result,
    output logic                       excp_ale,
    output logic [mem_pkg::XLEN-1:0]   excp_pc
);

    logic                       sel_valid;
    mem_pkg::mem_op_e           sel_op;
    mem_pkg::mem_width_e        sel_width;
    logic                       sel_unsigned;
    logic [mem_pkg::XLEN-1:0]   sel_addr;
    logic [mem_pkg::XLEN-1:0]   sel_wdata;
    logic [mem_pkg::XLEN-1:0]   sel_pc;

    logic                       ram_req;
    logic                       ram_we;
    logic [mem_pkg::XLEN-1:0]   ram_addr;
    logic [mem_pkg::XLEN-1:0]   ram_wdata;
    logic [3:0]                 ram_be;
    logic                       ram_ack;
    logic [mem_pkg::XLEN-1:0]   ram_rdata;

    mem_pkg::mem_width_e        op_width;
    logic                       op_unsigned;
    logic [mem_pkg::XLEN-1:0]   op_wdata;
    logic [mem_pkg::XLEN-1:0]   ext_data;

    mem_lane_select u_lane_select (
        .l0_op(l0_op), .l0_width(l0_width), .l0_unsigned(l0_unsigned),
        .l0_addr(l0_addr), .l0_wdata(l0_wdata), .l0_pc(l0_pc),
        .l1_op(l1_op), .l1_width(l1_width), .l1_unsigned(l1_unsigned),
        .l1_addr(l1_addr), .l1_wdata(l1_wdata), .l1_pc(l1_pc),
        .flush(flush),
        .sel_valid(sel_valid), .sel_op(sel_op), .sel_width(sel_width),
        .sel_unsigned(sel_unsigned), .sel_addr(sel_addr),
        .sel_wdata(sel_wdata), .sel_pc(sel_pc)
    );

    ms_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .sel_valid(sel_valid), .sel_op(sel_op), .sel_width(sel_width),
        .sel_unsigned(sel_unsigned), .sel_addr(sel_addr),
        .sel_wdata(sel_wdata), .sel_pc(sel_pc),
        .ram_ack(ram_ack), .ext_data(ext_data),
        .ram_req(ram_req), .ram_we(ram_we), .ram_addr(ram_addr),
        .op_width(op_width), .op_unsigned(op_unsigned), .op_wdata(op_wdata),
        .ms_done(ms_done), .ms_result(ms_result),
        .excp_ale(excp_ale), .excp_pc(excp_pc)
    );

    // Store data lanes from the registered operation
    store_format u_store_fmt (
        .addr(ram_addr), .width(op_width), .wdata(op_wdata),
        .ram_wdata(ram_wdata), .ram_be(ram_be)
    );

    load_extend u_load_ext (
        .rdata(ram_rdata), .addr_lo(ram_addr[1:0]), .width(op_width),
        .is_unsigned(op_unsigned), .ext_data(ext_data)
    );

    data_ram #(.RAM_DEPTH(RAM_DEPTH)) u_ram (
        .clk(clk), .rst_n(rst_n),
        .req(ram_req), .we(ram_we), .addr(ram_addr),
        .wdata(ram_wdata), .be(ram_be),
        .ack(ram_ack), .rdata(ram_rdata)
    );

endmodule

// File: data_ram.sv
`timescale 1ns/1ns

module data_ram #(
    parameter int unsigned RAM_DEPTH = 256
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req,
    input  logic                       we,
    input  logic [mem_pkg::XLEN-1:0]   addr,
    input  logic [mem_pkg::XLEN-1:0]   wdata,
    input  logic [3:0]                 be,
    output logic                       ack,
    output logic [mem_pkg::XLEN-1:0]   rdata
);

    localparam int IDX_W = (RAM_DEPTH > 1) ? $clog2(RAM_DEPTH) : 1;

    logic [mem_pkg::XLEN-1:0] mem [RAM_DEPTH];
    logic [IDX_W-1:0] idx;

    // Word index wraps over the array
    assign idx = IDX_W'(addr[mem_pkg::XLEN-1:2] % RAM_DEPTH);

    always_ff @(posedge clk) begin
        if (req && we) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b])
                    mem[idx][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
        if (req && !we)
            rdata <= mem[idx];
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            ack <= 1'b0;
        else
            ack <= req;  // One cycle latency
    end

    // The single-port controller never streams requests
    req_spaced: assert property (@(posedge clk) disable iff (!rst_n)
        req |=> !req)
        else $error("back-to-back RAM requests");

endmodule

// File: load_extend.sv
`timescale 1ns/1ns

module load_extend (
    input  logic [mem_pkg::XLEN-1:0]   rdata,
    input  logic [1:0]                 addr_lo,
    input  mem_pkg::mem_width_e        width,
    input  logic                       is_unsigned,
    output logic [mem_pkg::XLEN-1:0]   ext_data
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    always_comb begin
        case (addr_lo)
            2'd0:    byte_sel = rdata[7:0];
            2'd1:    byte_sel = rdata[15:8];
            2'd2:    byte_sel = rdata[23:16];
            default: byte_sel = rdata[31:24];
        endcase
    end

    assign half_sel = addr_lo[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (width)
            mem_pkg::W_BYTE: begin
                if (is_unsigned)
                    ext_data = {{(mem_pkg::XLEN-8){1'b0}}, byte_sel};
                else
                    ext_data = {{(mem_pkg::XLEN-8){byte_sel[7]}}, byte_sel};
            end
            mem_pkg::W_HALF: begin
                if (is_unsigned)
                    ext_data = {{(mem_pkg::XLEN-16){1'b0}}, half_sel};
                else
                    ext_data = {{(mem_pkg::XLEN-16){half_sel[15]}}, half_sel};
            end
            default: ext_data = rdata;  // Word passes through
        endcase
    end

endmodule

// File: store_format.sv
`timescale 1ns/1ns

module store_format (
    input  logic [mem_pkg::XLEN-1:0]   addr,
    input  mem_pkg::mem_width_e        width,
    input  logic [mem_pkg::XLEN-1:0]   wdata,
    output logic [mem_pkg::XLEN-1:0]   ram_wdata,
    output logic [3:0]                 ram_be
);

    logic [1:0] offs;

    assign offs = addr[1:0];

    // Data is replicated across lanes, the strobe picks the lane written
    always_comb begin
        case (width)
            mem_pkg::W_BYTE: begin
                ram_wdata = {4{wdata[7:0]}};
                ram_be    = 4'b0001 << offs;
            end
            mem_pkg::W_HALF: begin
                ram_wdata = {2{wdata[15:0]}};
                ram_be    = offs[1] ? 4'b1100 : 4'b0011;  // Upper or lower half
            end
            mem_pkg::W_WORD: begin
                ram_wdata = wdata;
                ram_be    = 4'b1111;
            end
            default: begin
                ram_wdata = wdata;
                ram_be    = 4'b0000;  // Unused encoding writes nothing
            end
        endcase
    end

endmodule

// File: ms_ctrl.sv
`timescale 1ns/1ns

module ms_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       sel_valid,
    input  mem_pkg::mem_op_e           sel_op,
    input  mem_pkg::mem_width_e        sel_width,
    input  logic                       sel_unsigned,
    input  logic [mem_pkg::XLEN-1:0]   sel_addr,
    input  logic [mem_pkg::XLEN-1:0]   sel_wdata,
    input  logic [mem_pkg::XLEN-1:0]   sel_pc,
    input  logic                       ram_ack,
    input  logic [mem_pkg::XLEN-1:0]   ext_data,
    output logic                       ram_req,
    output logic                       ram_we,
    output logic [mem_pkg::XLEN-1:0]   ram_addr,
    output mem_pkg::mem_width_e        op_width,
    output logic                       op_unsigned,
    output logic [mem_pkg::XLEN-1:0]   op_wdata,
    output logic                       ms_done,
    output logic [mem_pkg::XLEN-1:0]   ms_result,
    output logic                       excp_ale,
    output logic [mem_pkg::XLEN-1:0]   excp_pc
);

    mem_pkg::ms_state_e state;
    mem_pkg::mem_op_e   op_q;
    logic [mem_pkg::XLEN-1:0] pc_q;
    logic misaligned;
    logic accept;
    logic ram_done;

    // Halfword needs bit 0 clear, word needs both low bits clear
    always_comb begin
        case (sel_width)
            mem_pkg::W_HALF: misaligned = sel_addr[0];
            mem_pkg::W_WORD: misaligned = |sel_addr[1:0];
            default:         misaligned = 1'b0;
        endcase
    end

    assign accept = sel_valid && (state == mem_pkg::S_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= mem_pkg::S_IDLE;
            excp_ale <= 1'b0;
        end else begin
            excp_ale <= accept && misaligned;  // Exception finishes one cycle after issue
            case (state)
                mem_pkg::S_IDLE: begin
                    if (accept && !misaligned)
                        state <= mem_pkg::S_REQ;
                end
                mem_pkg::S_REQ:  state <= mem_pkg::S_WAIT;
                mem_pkg::S_WAIT: begin
                    if (ram_ack)
                        state <= mem_pkg::S_IDLE;
                end
                default:         state <= mem_pkg::S_IDLE;
            endcase
        end
    end

    // Operation payload
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q        <= sel_op;
            op_width    <= sel_width;
            op_unsigned <= sel_unsigned;
            ram_addr    <= sel_addr;
            op_wdata    <= sel_wdata;
            pc_q        <= sel_pc;
        end
    end

    assign ram_req  = (state == mem_pkg::S_REQ);
    assign ram_we   = (op_q == mem_pkg::MEM_STORE);
    assign ram_done = (state == mem_pkg::S_WAIT) && ram_ack;

    assign ms_done   = ram_done || excp_ale;
    assign ms_result = (ram_done && op_q == mem_pkg::MEM_LOAD) ? ext_data : '0;
    assign excp_pc   = excp_ale ? pc_q : '0;

    // RAM answers only the request this FSM made
    ack_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        ram_ack |-> state == mem_pkg::S_WAIT)
        else $error("ram_ack outside S_WAIT");

    // No back-pressure, a busy stage drops the issue
    issue_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        sel_valid |-> state == mem_pkg::S_IDLE)
        else $error("issue dropped while memory stage busy");

    done_single: assert property (@(posedge clk) disable iff (!rst_n)
        ms_done |=> !ms_done)
        else $error("ms_done high two cycles in a row");

endmodule

// File: mem_lane_select.sv
`timescale 1ns/1ns

module mem_lane_select (
    input  mem_pkg::mem_op_e           l0_op,
    input  mem_pkg::mem_width_e        l0_width,
    input  logic                       l0_unsigned,
    input  logic [mem_pkg::XLEN-1:0]   l0_addr,
    input  logic [mem_pkg::XLEN-1:0]   l0_wdata,
    input  logic [mem_pkg::XLEN-1:0]   l0_pc,
    input  mem_pkg::mem_op_e           l1_op,
    input  mem_pkg::mem_width_e        l1_width,
    input  logic                       l1_unsigned,
    input  logic [mem_pkg::XLEN-1:0]   l1_addr,
    input  logic [mem_pkg::XLEN-1:0]   l1_wdata,
    input  logic [mem_pkg::XLEN-1:0]   l1_pc,
    input  logic                       flush,
    output logic                       sel_valid,
    output mem_pkg::mem_op_e           sel_op,
    output mem_pkg::mem_width_e        sel_width,
    output logic                       sel_unsigned,
    output logic [mem_pkg::XLEN-1:0]   sel_addr,
    output logic [mem_pkg::XLEN-1:0]   sel_wdata,
    output logic [mem_pkg::XLEN-1:0]   sel_pc
);

    always_comb begin
        sel_op       = mem_pkg::MEM_NONE;
        sel_width    = mem_pkg::W_BYTE;
        sel_unsigned = 1'b0;
        sel_addr     = '0;
        sel_wdata    = '0;
        sel_pc       = '0;
        if (l0_op != mem_pkg::MEM_NONE) begin  // Older lane first
            sel_op       = l0_op;
            sel_width    = l0_width;
            sel_unsigned = l0_unsigned;
            sel_addr     = l0_addr;
            sel_wdata    = l0_wdata;
            sel_pc       = l0_pc;
        end else if (l1_op != mem_pkg::MEM_NONE) begin
            sel_op       = l1_op;
            sel_width    = l1_width;
            sel_unsigned = l1_unsigned;
            sel_addr     = l1_addr;
            sel_wdata    = l1_wdata;
            sel_pc       = l1_pc;
        end
    end

    assign sel_valid = (sel_op != mem_pkg::MEM_NONE) && !flush;  // Flush cancels the issue

endmodule

// File: mem_pkg.sv
package mem_pkg;

    // Data and address width of the core
    localparam int XLEN = 32;

    // Memory operation offered by a lane
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // Access width
    typedef enum logic [1:0] {
        W_BYTE = 2'd0,
        W_HALF = 2'd1,
        W_WORD = 2'd2
    } mem_width_e;

    // Memory stage control FSM
    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_REQ  = 2'd1,  // RAM request strobe
        S_WAIT = 2'd2   // Waiting for RAM ack
    } ms_state_e;

endpackage
